//--- src/mips_pkg.sv
package mips_pkg;

	// Core data width, fixed at 32
	localparam int word_width = 32;

	typedef logic [word_width-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	// Word address into instruction memory
	typedef logic [word_width-1:0] pc_t;

	// Primary opcodes of the subset
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addiu = 6'h09,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_halt  = 6'h3f
	} opcode_e;

	// R-type function codes
	typedef enum logic [5:0] {
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_slt  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_lui, alu_pass_b
	} alu_op_e;

	typedef enum logic [2:0] {
		br_none, br_beq, br_bne, br_jump, br_jr
	} branch_e;

	// HALT is the all-ones word
	localparam word_t halt_instr = '1;

	// Fetch to decode
	typedef struct packed {
		pc_t   pc;
		word_t instr;
	} fetch_item_t;

	// Decode to execute
	typedef struct packed {
		pc_t         pc;
		reg_addr_t   rs;
		reg_addr_t   rt;
		word_t       rs_val;
		word_t       rt_val;
		word_t       imm;
		logic [25:0] jidx;
		alu_op_e     alu_op;
		branch_e     branch;
		logic        use_imm;
		reg_addr_t   dest;
		logic        we;
	} decode_item_t;

	////////////////////////////////////////
	// Debug address map, byte addresses
	////////////////////////////////////////
	localparam logic [15:0] dbg_imem_base = 16'h0000;
	localparam logic [15:0] dbg_reg_base  = 16'h2000;
	localparam int          dbg_reg_count = 32;
	localparam logic [15:0] dbg_ctrl      = 16'h3000;
	localparam logic [15:0] dbg_status    = 16'h3004;

endpackage

//--- src/stage_link.sv
`timescale 1ns/1ps

interface stage_link #(
	parameter type payload_t = logic
) ();

	// Item handed from one stage to the next
	logic     valid;
	payload_t payload;
	// Destination accepts this cycle
	logic     advance;
	// Taken branch in execute kills younger items
	logic     flush;

	// Producing stage
	modport src (
		output valid,
		output payload,
		input  advance,
		input  flush
	);

	// Consuming stage
	modport dst (
		input  valid,
		input  payload,
		output advance
	);

endinterface

//--- src/instruction_fetch.sv
`timescale 1ns/1ps

module instruction_fetch #(
	parameter int IMEM_DEPTH_LOG2 = 11
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              run,
	input  logic              restart,
	input  logic              redirect,
	input  mips_pkg::pc_t     redirect_pc,
	input  logic              imem_we,
	input  mips_pkg::pc_t     imem_addr,
	input  mips_pkg::word_t   imem_wdata,
	output mips_pkg::word_t   imem_rdata,
	output logic              halted,
	stage_link.src            fd
);

	import mips_pkg::*;

	localparam int depth = 1 << IMEM_DEPTH_LOG2;

	word_t mem [0:depth-1];

	pc_t   pc;
	pc_t   item_pc_q;
	word_t instr_q;
	logic  valid_q;
	logic  halt_word;
	logic  halt_seen;
	logic  step;

	// Halt word sitting at the memory output
	assign halt_word = valid_q && (instr_q == halt_instr);
	// Ignored when a branch ahead of it redirects
	assign halt_seen = halt_word && !fd.flush;
	// Advance only while running and not halting
	assign step = run && fd.advance && !halted && !halt_seen;

	////////////////////////////////////////
	// Instruction memory
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (imem_we)
			mem[imem_addr[IMEM_DEPTH_LOG2-1:0]] <= imem_wdata;
		// Synchronous read, output one cycle after PC
		if (step) begin
			instr_q   <= mem[pc[IMEM_DEPTH_LOG2-1:0]];
			item_pc_q <= pc;
		end
	end

	// Debug read port, combinational
	assign imem_rdata = mem[imem_addr[IMEM_DEPTH_LOG2-1:0]];

	////////////////////////////////////////
	// PC, item valid and halt state
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc      <= '0;
			valid_q <= 1'b0;
			halted  <= 1'b0;
		end else if (restart) begin
			pc      <= '0;
			valid_q <= 1'b0;
			halted  <= 1'b0;
		end else begin
			if (step) begin
				// Output after a redirect is stale
				valid_q <= !fd.flush;
				pc      <= redirect ? redirect_pc : pc + pc_t'(1);
			end
			// Sticky until restart
			if (run && halt_seen)
				halted <= 1'b1;
		end
	end

	// HALT itself is never handed on
	assign fd.valid         = valid_q && !halt_word && !fd.flush;
	assign fd.payload.pc    = item_pc_q;
	assign fd.payload.instr = instr_q;

endmodule

//--- src/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode (
	input  logic                clk,
	input  logic                reset,
	input  logic                run,
	input  logic                wb_en,
	input  mips_pkg::reg_addr_t wb_addr,
	input  mips_pkg::word_t     wb_data,
	input  mips_pkg::reg_addr_t reg_raddr,
	output mips_pkg::word_t     reg_rdata,
	stage_link.dst              fd,
	stage_link.src              de
);

	import mips_pkg::*;

	word_t        rf [0:31];
	word_t        instr;
	opcode_e      opcode;
	funct_e       funct;
	decode_item_t item_d;
	decode_item_t item_q;
	logic         valid_q;

	// Register read, write-back wins over array
	function automatic word_t read_reg(input reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (wb_en && wb_addr == addr)
			return wb_data;
		return rf[addr];
	endfunction

	////////////////////////////////////////
	// Register file
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		// r0 never written
		if (wb_en && wb_addr != '0)
			rf[wb_addr] <= wb_data;
	end

	always_comb begin
		reg_rdata = read_reg(reg_raddr);
	end

	////////////////////////////////////////
	// Field extraction and control
	////////////////////////////////////////
	assign instr  = fd.payload.instr;
	assign opcode = opcode_e'(instr[31:26]);
	assign funct  = funct_e'(instr[5:0]);

	always_comb begin
		item_d         = '0;
		item_d.pc      = fd.payload.pc;
		item_d.rs      = instr[25:21];
		item_d.rt      = instr[20:16];
		item_d.rs_val  = read_reg(instr[25:21]);
		item_d.rt_val  = read_reg(instr[20:16]);
		// Sign extension unless overridden below
		item_d.imm     = {{16{instr[15]}}, instr[15:0]};
		item_d.jidx    = instr[25:0];
		item_d.alu_op  = alu_pass_b;
		item_d.branch  = br_none;
		item_d.use_imm = 1'b0;
		item_d.dest    = instr[15:11];
		item_d.we      = 1'b0;
		case (opcode)
			op_rtype: begin
				item_d.we = 1'b1;
				case (funct)
					fn_addu: item_d.alu_op = alu_add;
					fn_subu: item_d.alu_op = alu_sub;
					fn_and:  item_d.alu_op = alu_and;
					fn_or:   item_d.alu_op = alu_or;
					fn_xor:  item_d.alu_op = alu_xor;
					fn_slt:  item_d.alu_op = alu_slt;
					fn_jr: begin
						item_d.branch = br_jr;
						item_d.we     = 1'b0;
					end
					default: item_d.we = 1'b0;
				endcase
			end
			op_addiu, op_andi, op_ori, op_lui: begin
				// Immediate forms write rt
				item_d.use_imm = 1'b1;
				item_d.dest    = instr[20:16];
				item_d.we      = 1'b1;
				case (opcode)
					op_addiu: item_d.alu_op = alu_add;
					op_andi:  item_d.alu_op = alu_and;
					op_ori:   item_d.alu_op = alu_or;
					default:  item_d.alu_op = alu_lui;
				endcase
				// Logical immediates zero extended
				if (opcode == op_andi || opcode == op_ori)
					item_d.imm = {16'b0, instr[15:0]};
			end
			op_beq: item_d.branch = br_beq;
			op_bne: item_d.branch = br_bne;
			op_j:   item_d.branch = br_jump;
			// HALT and unknown opcodes do nothing
			default: ;
		endcase
	end

	////////////////////////////////////////
	// Decode pipeline register
	////////////////////////////////////////
	assign fd.advance = run && de.advance;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			valid_q <= 1'b0;
		else if (fd.advance)
			valid_q <= fd.valid && !de.flush;
	end

	always_ff @(posedge clk) begin
		if (fd.advance)
			item_q <= item_d;
	end

	// Held item is not executed again while stopped
	assign de.valid   = valid_q && run;
	assign de.payload = item_q;

endmodule

//--- src/execute.sv
`timescale 1ns/1ps

module execute (
	input  logic                clk,
	input  logic                reset,
	stage_link.dst              de,
	output logic                redirect,
	output mips_pkg::pc_t       redirect_pc,
	output logic                wb_en,
	output mips_pkg::reg_addr_t wb_addr,
	output mips_pkg::word_t     wb_data
);

	import mips_pkg::*;

	decode_item_t it;
	reg_addr_t    prev_dest;
	logic         prev_we;
	word_t        prev_result;
	word_t        op_a;
	word_t        op_b_reg;
	word_t        op_b;
	word_t        result;
	logic         taken;

	assign it = de.payload;

	// Single cycle, always accepts
	assign de.advance = 1'b1;

	////////////////////////////////////////
	// Forwarding of previous result
	////////////////////////////////////////
	assign op_a = (prev_we && prev_dest != '0 && prev_dest == it.rs) ?
		prev_result : it.rs_val;
	assign op_b_reg = (prev_we && prev_dest != '0 && prev_dest == it.rt) ?
		prev_result : it.rt_val;
	assign op_b = it.use_imm ? it.imm : op_b_reg;

	// ALU
	always_comb begin
		case (it.alu_op)
			alu_add: result = op_a + op_b;
			alu_sub: result = op_a - op_b;
			alu_and: result = op_a & op_b;
			alu_or:  result = op_a | op_b;
			alu_xor: result = op_a ^ op_b;
			alu_slt: result = word_t'($signed(op_a) < $signed(op_b));
			alu_lui: result = {op_b[15:0], 16'b0};
			default: result = op_b;
		endcase
	end

	////////////////////////////////////////
	// Branch and jump resolution
	////////////////////////////////////////
	always_comb begin
		taken       = 1'b0;
		redirect_pc = it.pc + pc_t'(1) + it.imm;
		case (it.branch)
			br_beq: taken = (op_a == op_b_reg);
			br_bne: taken = (op_a != op_b_reg);
			br_jump: begin
				taken       = 1'b1;
				redirect_pc = pc_t'(it.jidx);
			end
			br_jr: begin
				taken       = 1'b1;
				redirect_pc = op_a;
			end
			default: taken = 1'b0;
		endcase
	end

	assign redirect = de.valid && taken;

	// Register write-back at end of cycle
	assign wb_en   = de.valid && it.we;
	assign wb_addr = it.dest;
	assign wb_data = result;

	// Remember last executed destination and result
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			prev_we   <= 1'b0;
			prev_dest <= '0;
		end else if (de.valid && de.advance) begin
			prev_we   <= it.we;
			prev_dest <= it.dest;
		end
	end

	always_ff @(posedge clk) begin
		if (de.valid && de.advance)
			prev_result <= result;
	end

endmodule

//--- src/apb_debug_port.sv
`timescale 1ns/1ps

module apb_debug_port #(
	parameter int IMEM_DEPTH_LOG2 = 11
) (
	input  logic                clk,
	input  logic                reset,
	input  logic [15:0]         paddr,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  mips_pkg::word_t     pwdata,
	input  logic                halted,
	input  mips_pkg::word_t     imem_rdata,
	input  mips_pkg::word_t     reg_rdata,
	output mips_pkg::word_t     prdata,
	output logic                pready,
	output logic                pslverr,
	output logic                imem_we,
	output mips_pkg::pc_t       imem_addr,
	output mips_pkg::word_t     imem_wdata,
	output mips_pkg::reg_addr_t reg_raddr,
	output logic                run,
	output logic                restart
);

	import mips_pkg::*;

	logic access;
	logic aligned;
	logic is_imem;
	logic is_reg;
	logic is_ctrl;
	logic is_status;
	logic error;

	// Access phase, always completes in one cycle
	assign access = psel && penable;
	assign pready = access;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////
	assign aligned   = (paddr[1:0] == 2'b00);
	assign is_imem   = aligned && paddr < dbg_reg_base &&
		((paddr - dbg_imem_base) >> 2) < (1 << IMEM_DEPTH_LOG2);
	assign is_reg    = aligned && paddr >= dbg_reg_base &&
		paddr < dbg_reg_base + 16'(dbg_reg_count * 4);
	assign is_ctrl   = (paddr == dbg_ctrl);
	assign is_status = (paddr == dbg_status);

	assign imem_addr  = pc_t'((paddr - dbg_imem_base) >> 2);
	assign imem_wdata = pwdata;
	assign reg_raddr  = reg_addr_t'((paddr - dbg_reg_base) >> 2);

	// Unmapped, imem write or register read while running
	assign error = !(is_imem || is_reg || is_ctrl || is_status) ||
		(is_imem && pwrite && run) ||
		(is_reg && !pwrite && run);
	assign pslverr = access && error;

	// Failed writes never reach the memory
	assign imem_we = access && pwrite && is_imem && !run;

	always_comb begin
		prdata = '0;
		if (is_imem)
			prdata = imem_rdata;
		else if (is_reg && !run)
			prdata = reg_rdata;
		else if (is_ctrl)
			prdata = word_t'(run);
		else if (is_status)
			prdata = word_t'(halted);
	end

	////////////////////////////////////////
	// Run control
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			run     <= 1'b0;
			restart <= 1'b0;
		end else begin
			// Restart lasts one cycle
			restart <= 1'b0;
			if (access && pwrite && is_ctrl) begin
				run     <= pwdata[0];
				restart <= pwdata[1];
			end
		end
	end

endmodule

//--- src/mips_core.sv
`timescale 1ns/1ps

module mips_core #(
	parameter int IMEM_DEPTH_LOG2 = 11
) (
	input  logic            clk,
	input  logic            reset,
	// APB debug port
	input  logic [15:0]     paddr,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  mips_pkg::word_t pwdata,
	output mips_pkg::word_t prdata,
	output logic            pready,
	output logic            pslverr,
	output logic            halted
);

	import mips_pkg::*;

	logic      run;
	logic      restart;
	logic      redirect;
	pc_t       redirect_pc;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      imem_we;
	pc_t       imem_addr;
	word_t     imem_wdata;
	word_t     imem_rdata;
	reg_addr_t reg_raddr;
	word_t     reg_rdata;

	////////////////////////////////////////
	// Stage links
	////////////////////////////////////////
	stage_link #(.payload_t(fetch_item_t)) fd_link ();
	stage_link #(.payload_t(decode_item_t)) de_link ();

	// Taken branch flushes both younger stages
	assign fd_link.flush = redirect;
	assign de_link.flush = redirect;

	instruction_fetch #(
		.IMEM_DEPTH_LOG2(IMEM_DEPTH_LOG2)
	) instruction_fetch_i (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.restart     (restart),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_wdata  (imem_wdata),
		.imem_rdata  (imem_rdata),
		.halted      (halted),
		.fd          (fd_link.src)
	);

	instruction_decode instruction_decode_i (
		.clk       (clk),
		.reset     (reset),
		.run       (run),
		.wb_en     (wb_en),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.reg_raddr (reg_raddr),
		.reg_rdata (reg_rdata),
		.fd        (fd_link.dst),
		.de        (de_link.src)
	);

	execute execute_i (
		.clk         (clk),
		.reset       (reset),
		.de          (de_link.dst),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.wb_en       (wb_en),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	// Debug access and run control
	apb_debug_port #(
		.IMEM_DEPTH_LOG2(IMEM_DEPTH_LOG2)
	) apb_debug_port_i (
		.clk        (clk),
		.reset      (reset),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.halted     (halted),
		.imem_rdata (imem_rdata),
		.reg_rdata  (reg_rdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.reg_raddr  (reg_raddr),
		.run        (run),
		.restart    (restart)
	);

endmodule

//--- dv/mips_core_chk.sv
`timescale 1ns/1ps

module mips_core_chk (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic imem_we,
	input logic redirect,
	input logic de_valid
);

	// Failed assertions so far, summed into the testbench error count
	int fail_count = 0;

	////////////////////////////////////////
	// APB protocol
	////////////////////////////////////////

	// Setup phase goes straight to access
	setup_then_access: assert property (
		@(posedge clk) disable iff (reset)
		psel && !penable |=> psel && penable
	) else begin
		$error("APB setup phase not followed by an access phase");
		fail_count++;
	end

	// Access phase lasts one cycle once ready
	access_one_cycle: assert property (
		@(posedge clk) disable iff (reset)
		psel && penable && pready |=> !penable
	) else begin
		$error("APB penable held after a completed transfer");
		fail_count++;
	end

	// Errors only in an access phase, refused writes never reach memory
	error_in_access: assert property (
		@(posedge clk) disable iff (reset)
		pslverr |-> psel && penable && !imem_we
	) else begin
		$error("pslverr high outside an access phase or with a memory write");
		fail_count++;
	end

	////////////////////////////////////////
	// Pipeline control
	////////////////////////////////////////

	// Only a live item redirects, then two bubbles reach execute
	redirect_flushes_two: assert property (
		@(posedge clk) disable iff (reset)
		redirect |-> de_valid ##1 !de_valid [*2]
	) else begin
		$error("redirect without a valid item, or a younger item survived the flush");
		fail_count++;
	end

endmodule

bind mips_core mips_core_chk mips_core_chk_i (
	.clk      (clk),
	.reset    (reset),
	.psel     (psel),
	.penable  (penable),
	.pready   (pready),
	.pslverr  (pslverr),
	.imem_we  (imem_we),
	.redirect (redirect),
	.de_valid (de_link.valid)
);

//--- dv/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb;

	import mips_pkg::*;

	localparam int imem_depth_log2 = 11;
	localparam int apb_timeout     = 16;
	localparam int halt_timeout    = 5000;
	localparam int model_limit     = 4096;

	logic        clk;
	logic        reset;
	logic [15:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	word_t       pwdata;
	word_t       prdata;
	logic        pready;
	logic        pslverr;
	logic        halted;

	// Program image, word addressed from 0
	word_t prog [$];
	// Architectural registers of the reference model
	word_t model_regs [0:31];

	int checks;
	int errors;
	int errors_before;
	int tests_run;
	int tests_bad;

	mips_core #(
		.IMEM_DEPTH_LOG2(imem_depth_log2)
	) mips_core_i (
		.clk     (clk),
		.reset   (reset),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.halted  (halted)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////
	// Checks and bookkeeping
	////////////////////////////////////////
	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: expected 0x%08h, got 0x%08h", name, exp, got);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp, got);
		end
	endtask

	// Own checks plus bound assertion failures
	function automatic int total_errors();
		return errors + mips_core_i.mips_core_chk_i.fail_count;
	endfunction

	task automatic finish_test(input string name);
		int found;
		found = total_errors() - errors_before;
		tests_run++;
		if (found != 0)
			tests_bad++;
		$display("%s: finished, %0d errors", name, found);
		errors_before = total_errors();
	endtask

	task automatic abort_run(input string why);
		$display("Timeout: %s", why);
		$display("Test failed");
		$finish;
	endtask

	////////////////////////////////////////
	// APB master
	////////////////////////////////////////
	task automatic apb_transfer(input logic [15:0] addr, input logic write, input word_t wdata,
			output word_t rdata, output logic err);
		int waited;
		// Setup phase
		@(negedge clk);
		paddr   = addr;
		pwrite  = write;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		// Access phase, held until pready
		@(negedge clk);
		penable = 1'b1;
		waited  = 0;
		@(posedge clk);
		while (!pready) begin
			waited++;
			if (waited > apb_timeout)
				abort_run("APB transfer got no pready");
			@(posedge clk);
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [15:0] addr, input word_t data, output logic err);
		word_t unused;
		apb_transfer(addr, 1'b1, data, unused, err);
	endtask

	task automatic apb_read(input logic [15:0] addr, output word_t data, output logic err);
		apb_transfer(addr, 1'b0, '0, data, err);
	endtask

	task automatic wait_halted();
		int waited;
		waited = 0;
		@(posedge clk);
		while (!halted) begin
			waited++;
			if (waited > halt_timeout)
				abort_run("core never raised halted");
			@(posedge clk);
		end
	endtask

	////////////////////////////////////////
	// Instruction encoding and generation
	////////////////////////////////////////
	function automatic word_t rtype_word(funct_e fn, reg_addr_t rs, reg_addr_t rt,
			reg_addr_t rd);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic word_t itype_word(opcode_e op, reg_addr_t rs, reg_addr_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jump_word(logic [25:0] idx);
		return {op_j, idx};
	endfunction

	function automatic reg_addr_t pick_reg();
		return reg_addr_t'($urandom_range(1, 31));
	endfunction

	// Full 32-bit random value in every register from lo up
	task automatic push_prologue(input int lo);
		int r;
		for (r = lo; r < 32; r++) begin
			prog.push_back(itype_word(op_lui, 5'd0, reg_addr_t'(r), 16'($urandom)));
			prog.push_back(itype_word(op_ori, reg_addr_t'(r), reg_addr_t'(r), 16'($urandom)));
		end
	endtask

	// Sources lean on the last destination to hit forwarding
	task automatic push_alu(inout reg_addr_t last, input logic allow_r0);
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		rs = $urandom_range(0, 1) ? last : pick_reg();
		rt = $urandom_range(0, 1) ? last : pick_reg();
		rd = (allow_r0 && $urandom_range(0, 3) == 0) ? 5'd0 : pick_reg();
		case ($urandom_range(0, 9))
			0: prog.push_back(rtype_word(fn_addu, rs, rt, rd));
			1: prog.push_back(rtype_word(fn_subu, rs, rt, rd));
			2: prog.push_back(rtype_word(fn_and, rs, rt, rd));
			3: prog.push_back(rtype_word(fn_or, rs, rt, rd));
			4: prog.push_back(rtype_word(fn_xor, rs, rt, rd));
			5: prog.push_back(rtype_word(fn_slt, rs, rt, rd));
			6: prog.push_back(itype_word(op_addiu, rs, rd, 16'($urandom)));
			7: prog.push_back(itype_word(op_andi, rs, rd, 16'($urandom)));
			8: prog.push_back(itype_word(op_ori, rs, rd, 16'($urandom)));
			default: prog.push_back(itype_word(op_lui, 5'd0, rd, 16'($urandom)));
		endcase
		last = rd;
	endtask

	////////////////////////////////////////
	// Reference model, one instruction at a time
	////////////////////////////////////////
	function automatic void write_model(input reg_addr_t r, input word_t v);
		// r0 stays zero
		if (r != 5'd0)
			model_regs[r] = v;
	endfunction

	task automatic run_model();
		pc_t       pc;
		pc_t       next_pc;
		word_t     ins;
		word_t     a;
		word_t     b;
		word_t     sext;
		word_t     zext;
		reg_addr_t rt;
		reg_addr_t rd;
		int        steps;
		logic      done;
		pc    = '0;
		steps = 0;
		done  = 1'b0;
		while (!done) begin
			if (pc >= prog.size() || steps >= model_limit) begin
				$display("Reference model left the program at pc %0d", pc);
				errors++;
				done = 1'b1;
			end else if (prog[pc] == 32'hffff_ffff) begin
				done = 1'b1;
			end else begin
				ins     = prog[pc];
				a       = model_regs[ins[25:21]];
				b       = model_regs[ins[20:16]];
				rt      = ins[20:16];
				rd      = ins[15:11];
				sext    = {{16{ins[15]}}, ins[15:0]};
				zext    = {16'h0000, ins[15:0]};
				next_pc = pc + 1;
				case (ins[31:26])
					// R-type, selected by funct
					6'h00: begin
						case (ins[5:0])
							6'h21: write_model(rd, a + b);
							6'h23: write_model(rd, a - b);
							6'h24: write_model(rd, a & b);
							6'h25: write_model(rd, a | b);
							6'h26: write_model(rd, a ^ b);
							6'h2a: write_model(rd, {31'b0, $signed(a) < $signed(b)});
							6'h08: next_pc = a;
							default: ;
						endcase
					end
					6'h09: write_model(rt, a + sext);
					6'h0c: write_model(rt, a & zext);
					6'h0d: write_model(rt, a | zext);
					6'h0f: write_model(rt, {ins[15:0], 16'h0000});
					// Branch target relative to the next word
					6'h04: if (a == b) next_pc = pc + 1 + sext;
					6'h05: if (a != b) next_pc = pc + 1 + sext;
					6'h02: next_pc = {6'b0, ins[25:0]};
					default: ;
				endcase
				pc = next_pc;
				steps++;
			end
		end
	endtask

	////////////////////////////////////////
	// Program run and register compare
	////////////////////////////////////////
	task automatic compare_registers();
		int    r;
		logic  err;
		word_t d;
		for (r = 0; r < 32; r++) begin
			apb_read(dbg_reg_base + 16'(r * 4), d, err);
			check_flag("pslverr", err, 1'b0);
			check_word($sformatf("r%0d", r), d, model_regs[r]);
		end
	endtask

	task automatic start_and_wait();
		logic err;
		apb_write(dbg_ctrl, 32'h1, err);
		check_flag("pslverr", err, 1'b0);
		wait_halted();
		// Stop so registers can be read
		apb_write(dbg_ctrl, 32'h0, err);
		check_flag("pslverr", err, 1'b0);
	endtask

	task automatic run_program();
		int   i;
		logic err;
		// Stop plus restart, PC back to 0
		apb_write(dbg_ctrl, 32'h2, err);
		check_flag("pslverr", err, 1'b0);
		for (i = 0; i < prog.size(); i++) begin
			apb_write(dbg_imem_base + 16'(i * 4), prog[i], err);
			check_flag("pslverr", err, 1'b0);
		end
		run_model();
		start_and_wait();
		compare_registers();
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////
	task automatic imem_readback();
		int    addrs [64];
		word_t words [64];
		int    i;
		logic  err;
		word_t d;
		// One word in each 32-word slice of memory
		for (i = 0; i < 64; i++) begin
			addrs[i] = i * 32 + $urandom_range(0, 31);
			words[i] = $urandom;
			apb_write(dbg_imem_base + 16'(addrs[i] * 4), words[i], err);
			check_flag("pslverr", err, 1'b0);
		end
		for (i = 0; i < 64; i++) begin
			apb_read(dbg_imem_base + 16'(addrs[i] * 4), d, err);
			check_flag("pslverr", err, 1'b0);
			check_word($sformatf("imem[%0d]", addrs[i]), d, words[i]);
		end
	endtask

	task automatic alu_forwarding();
		reg_addr_t last;
		prog.delete();
		push_prologue(1);
		last = 5'd31;
		repeat (48) push_alu(last, 1'b0);
		prog.push_back(halt_instr);
		run_program();
	endtask

	task automatic branch_flush();
		reg_addr_t last;
		reg_addr_t rs;
		reg_addr_t rt;
		int        skip;
		int        target;
		prog.delete();
		push_prologue(1);
		last = 5'd31;
		repeat (16) begin
			skip = $urandom_range(1, 3);
			rs   = $urandom_range(0, 1) ? last : pick_reg();
			// Equal operands about half the time
			rt   = $urandom_range(0, 1) ? rs : pick_reg();
			case ($urandom_range(0, 3))
				0: prog.push_back(itype_word(op_beq, rs, rt, 16'(skip)));
				1: prog.push_back(itype_word(op_bne, rs, rt, 16'(skip)));
				2: begin
					target = prog.size() + 1 + skip;
					prog.push_back(jump_word(26'(target)));
				end
				default: begin
					// JR target loaded just before, so it comes forwarded
					rs     = pick_reg();
					target = prog.size() + 2 + skip;
					prog.push_back(itype_word(op_ori, 5'd0, rs, 16'(target)));
					prog.push_back(rtype_word(fn_jr, rs, 5'd0, 5'd0));
					last = rs;
				end
			endcase
			// Shadow, skipped when taken
			repeat (skip) push_alu(last, 1'b0);
			repeat (2) push_alu(last, 1'b0);
		end
		prog.push_back(halt_instr);
		run_program();
	endtask

	task automatic halt_and_restart();
		reg_addr_t last;
		logic      err;
		word_t     d;
		prog.delete();
		// Run counter in r1, outside the prologue
		prog.push_back(itype_word(op_addiu, 5'd1, 5'd1, 16'h0001));
		push_prologue(2);
		last = 5'd1;
		repeat (12) push_alu(last, 1'b0);
		prog.push_back(halt_instr);
		// Markers behind HALT
		prog.push_back(itype_word(op_addiu, 5'd0, 5'd5, 16'h7e57));
		prog.push_back(itype_word(op_lui, 5'd0, 5'd6, 16'hdead));
		prog.push_back(itype_word(op_ori, 5'd0, 5'd7, 16'hbeef));
		prog.push_back(rtype_word(fn_xor, 5'd5, 5'd6, 5'd8));
		run_program();
		apb_read(dbg_status, d, err);
		check_flag("halted", d[0], 1'b1);
		check_flag("halted", halted, 1'b1);
		// Restart alone clears halted
		apb_write(dbg_ctrl, 32'h2, err);
		check_flag("pslverr", err, 1'b0);
		apb_read(dbg_status, d, err);
		check_flag("halted", d[0], 1'b0);
		check_flag("halted", halted, 1'b0);
		// Second pass from PC 0
		run_model();
		start_and_wait();
		apb_read(dbg_status, d, err);
		check_flag("halted", d[0], 1'b1);
		check_flag("halted", halted, 1'b1);
		compare_registers();
	endtask

	task automatic zero_register();
		reg_addr_t last;
		logic      err;
		word_t     d;
		prog.delete();
		push_prologue(1);
		// Writes to r0, read back right away
		prog.push_back(itype_word(op_addiu, 5'd3, 5'd0, 16'h1234));
		prog.push_back(rtype_word(fn_addu, 5'd0, 5'd0, 5'd9));
		prog.push_back(itype_word(op_lui, 5'd0, 5'd0, 16'hffff));
		prog.push_back(rtype_word(fn_or, 5'd0, 5'd11, 5'd10));
		prog.push_back(rtype_word(fn_subu, 5'd12, 5'd13, 5'd0));
		prog.push_back(itype_word(op_ori, 5'd0, 5'd14, 16'h0005));
		last = 5'd0;
		repeat (16) push_alu(last, 1'b1);
		prog.push_back(halt_instr);
		run_program();
		apb_read(dbg_reg_base, d, err);
		check_word("r0", d, '0);
	endtask

	task automatic error_responses();
		logic  err;
		word_t d;
		// Unmapped read and write
		apb_read(16'h3008, d, err);
		check_flag("pslverr", err, 1'b1);
		apb_write(16'h4000, 32'h0000_0003, err);
		check_flag("pslverr", err, 1'b1);
		apb_read(dbg_ctrl, d, err);
		check_word("ctrl", d, 32'h0);
		apb_read(dbg_status, d, err);
		check_flag("halted", d[0], 1'b1);
		check_flag("halted", halted, 1'b1);
		// Run while halted, nothing executes
		apb_write(dbg_ctrl, 32'h1, err);
		check_flag("pslverr", err, 1'b0);
		// Word 4 still holds the last loaded program
		apb_write(dbg_imem_base + 16'h0010, ~prog[4], err);
		check_flag("pslverr", err, 1'b1);
		apb_read(dbg_imem_base + 16'h0010, d, err);
		check_flag("pslverr", err, 1'b0);
		check_word("imem[4]", d, prog[4]);
		// Register read refused while running
		apb_read(dbg_reg_base + 16'h000c, d, err);
		check_flag("pslverr", err, 1'b1);
		apb_write(dbg_ctrl, 32'h0, err);
		check_flag("pslverr", err, 1'b0);
		apb_read(dbg_reg_base + 16'h000c, d, err);
		check_flag("pslverr", err, 1'b0);
		check_word("r3", d, model_regs[3]);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		int r;
		reset   = 1'b1;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		checks        = 0;
		errors        = 0;
		errors_before = 0;
		tests_run     = 0;
		tests_bad     = 0;
		for (r = 0; r < 32; r++)
			model_regs[r] = '0;
		void'($urandom(32'h0ed302d5));
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		imem_readback();
		finish_test("imem load and readback");
		alu_forwarding();
		finish_test("alu program with forwarding");
		branch_flush();
		finish_test("branches and jumps");
		halt_and_restart();
		finish_test("halt and restart");
		zero_register();
		finish_test("register 0");
		error_responses();
		finish_test("error responses");

		$display("Tests: %0d run, %0d with errors; checks: %0d; errors: %0d",
			tests_run, tests_bad, checks, total_errors());
		if (total_errors() == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- sources.f
src/mips_pkg.sv
src/stage_link.sv
src/instruction_fetch.sv
src/instruction_decode.sv
src/execute.sv
src/apb_debug_port.sv
src/mips_core.sv
dv/mips_core_chk.sv
dv/mips_core_tb.sv
